/* include/slot_bus_params.svh */
// Frame length, port count and configuration address map of the serial slot bus
// Included by the package and by any RTL that sizes or decodes against these values

`ifndef SLOT_BUS_PARAMS_SVH
`define SLOT_BUS_PARAMS_SVH

// Bits shifted per frame, one latch pulse each
`define SLOT_FRAME_BITS 8

// Converter ports on the isolated bus
`define SLOT_NUM_PORTS 4

// Configuration address of the clock-select mask
// Addresses below SLOT_NUM_PORTS hold the per-port hardware-configuration bytes
`define SLOT_CFG_CLKSEL_ADDR 4

`endif

/* source/slot_bus_pkg.sv */
// Vector types shared by the slot bus RTL and its testbench
// Referenced as slot_bus_pkg::name

`include "slot_bus_params.svh"

package slot_bus_pkg;

    // One frame's payload
    typedef logic [`SLOT_FRAME_BITS-1:0] frame_word_t;

    // One bit per converter port
    typedef logic [`SLOT_NUM_PORTS-1:0] port_mask_t;

    // Per-port hardware-configuration byte
    typedef logic [7:0] hwcon_t;

    // Configuration register address
    typedef logic [2:0] cfg_addr_t;

    // Bit position within a frame
    typedef logic [$clog2(`SLOT_FRAME_BITS)-1:0] bit_index_t;

    // Port number
    typedef logic [$clog2(`SLOT_NUM_PORTS)-1:0] port_index_t;

endpackage

/* source/frame_timer.sv */
// Frame timer for the serial slot bus that makes the latch pulse and the hwcon port index

`timescale 1ns/1ps

module frame_timer (
    input  logic                      custom_srclk,
    input  logic                      reset,
    output logic                      frame_start,
    output slot_bus_pkg::port_index_t hwcon_port
);

    slot_bus_pkg::bit_index_t bit_cnt;

    // Free-running bit position that wraps once per frame and is zero on the first bit
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign frame_start = (bit_cnt == '0);

    // Steps once per frame so frames carry ports 0, 1, 2, 3 in turn
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            hwcon_port <= '0;
        end else if (frame_start) begin
            hwcon_port <= hwcon_port + 1'b1;
        end
    end

endmodule

/* source/slot_config_regs.sv */
// Configuration registers for the slot bus: per-port hwcon bytes and clock-select mask
// Written by address with a single-cycle strobe, hwcon read out by the rotating port index

`timescale 1ns/1ps

`include "slot_bus_params.svh"

module slot_config_regs (
    input  logic                      custom_srclk,
    input  logic                      reset,
    input  logic                      cfg_write,
    input  slot_bus_pkg::cfg_addr_t   cfg_addr,
    input  slot_bus_pkg::frame_word_t cfg_data,
    input  slot_bus_pkg::port_index_t hwcon_port,
    output slot_bus_pkg::port_mask_t  clksel,
    output slot_bus_pkg::hwcon_t      hwcon
);

    slot_bus_pkg::hwcon_t hwcon_q [`SLOT_NUM_PORTS];

    logic hwcon_hit;
    logic clksel_hit;

    // Address decode, anything above the clock-select address is dropped
    assign hwcon_hit  = (cfg_addr < slot_bus_pkg::cfg_addr_t'(`SLOT_NUM_PORTS));
    assign clksel_hit = (cfg_addr == slot_bus_pkg::cfg_addr_t'(`SLOT_CFG_CLKSEL_ADDR));

    // Hardware-configuration bytes, one per port
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `SLOT_NUM_PORTS; i++) begin
                hwcon_q[i] <= '0;
            end
        end else if (cfg_write && hwcon_hit) begin
            hwcon_q[slot_bus_pkg::port_index_t'(cfg_addr)] <= cfg_data;
        end
    end

    // Clock-select mask lives in the low nibble of the written word
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            clksel <= '0;
        end else if (cfg_write && clksel_hit) begin
            clksel <= cfg_data[`SLOT_NUM_PORTS-1:0];
        end
    end

    // Byte for the port whose frame loads next
    assign hwcon = hwcon_q[hwcon_port];

endmodule

/* source/frame_serializer.sv */
// Parallel-in serial-out register for one outgoing slot bus line
// Loads at frame start and shifts MSB first for the rest of the frame

`timescale 1ns/1ps

module frame_serializer (
    input  logic                      custom_srclk,
    input  logic                      reset,
    input  logic                      frame_start,
    input  slot_bus_pkg::frame_word_t word,
    output logic                      serial_out
);

    slot_bus_pkg::frame_word_t shift_q;

    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_q <= '0;
        end else if (frame_start) begin
            // New word takes over for the coming frame
            shift_q <= word;
        end else begin
            shift_q <= {shift_q[$bits(shift_q)-2:0], 1'b0};
        end
    end

    // MSB is on the line
    assign serial_out = shift_q[$bits(shift_q)-1];

endmodule

/* source/frame_deserializer.sv */
// Serial-in parallel-out register for one incoming slot bus line
// The parallel word is updated at frame start and holds for a whole frame

`timescale 1ns/1ps

module frame_deserializer (
    input  logic                      custom_srclk,
    input  logic                      reset,
    input  logic                      frame_start,
    input  logic                      serial_in,
    output slot_bus_pkg::frame_word_t word
);

    slot_bus_pkg::frame_word_t shift_q;
    slot_bus_pkg::frame_word_t shift_next;

    // Oldest sample works its way up to the MSB
    assign shift_next = {shift_q[$bits(shift_q)-2:0], serial_in};

    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_q <= '0;
        end else begin
            shift_q <= shift_next;
        end
    end

    // Holding register, includes the bit sampled on the latch edge
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (frame_start) begin
            word <= shift_next;
        end
    end

endmodule

/* source/slot_bus_top.sv */
// Serial control-bus expander for the audio converter ports
// Shifts chip selects, clock selects and hwcon out and overflow and dir/chan bits in

`timescale 1ns/1ps

module slot_bus_top (
    input  logic                      custom_srclk,
    input  logic                      reset,
    input  logic                      cfg_write,
    input  slot_bus_pkg::cfg_addr_t   cfg_addr,
    input  slot_bus_pkg::frame_word_t cfg_data,
    input  slot_bus_pkg::port_mask_t  spi_adc_sel,
    input  slot_bus_pkg::port_mask_t  spi_dac_sel,
    input  logic                      custom_adc_ovf,
    input  logic                      custom_dirchan,
    output logic                      bus_latch,
    output logic                      spi_adc_cs,
    output logic                      spi_dac_cs,
    output logic                      custom_clksel,
    output logic                      custom_adc_hwcon,
    output slot_bus_pkg::frame_word_t aovf,
    output slot_bus_pkg::port_mask_t  direction,
    output slot_bus_pkg::port_mask_t  num_channels
);

    logic                      frame_start;
    slot_bus_pkg::port_index_t hwcon_port;
    slot_bus_pkg::port_mask_t  clksel;
    slot_bus_pkg::hwcon_t      hwcon;

    slot_bus_pkg::frame_word_t adc_cs_word;
    slot_bus_pkg::frame_word_t dac_cs_word;
    slot_bus_pkg::frame_word_t clksel_word;
    slot_bus_pkg::frame_word_t dirchan_word;

    frame_timer u_timer (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .hwcon_port   (hwcon_port)
    );

    assign bus_latch = frame_start;

    slot_config_regs u_cfg (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .hwcon_port   (hwcon_port),
        .clksel       (clksel),
        .hwcon        (hwcon)
    );

    // Chip selects are active low on the board
    assign adc_cs_word = {4'b0000, ~spi_adc_sel};
    assign dac_cs_word = {4'b0000, ~spi_dac_sel};
    assign clksel_word = {4'b0000, clksel};

    frame_serializer u_ser_adc_cs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .word         (adc_cs_word),
        .serial_out   (spi_adc_cs)
    );

    frame_serializer u_ser_dac_cs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .word         (dac_cs_word),
        .serial_out   (spi_dac_cs)
    );

    frame_serializer u_ser_clksel (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .word         (clksel_word),
        .serial_out   (custom_clksel)
    );

    frame_serializer u_ser_hwcon (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .word         (hwcon),
        .serial_out   (custom_adc_hwcon)
    );

    frame_deserializer u_deser_ovf (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .serial_in    (custom_adc_ovf),
        .word         (aovf)
    );

    frame_deserializer u_deser_dirchan (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_start  (frame_start),
        .serial_in    (custom_dirchan),
        .word         (dirchan_word)
    );

    // Upper nibble is channel count, lower nibble is direction
    assign num_channels = dirchan_word[7:4];
    assign direction    = dirchan_word[3:0];

endmodule

/* dv/slot_bus_props.sv */
// Assertions for the slot bus top level that the testbench binds to slot_bus_top
// Checks the latch spacing and the idle serial lines during reset

`timescale 1ns/1ps

module slot_bus_props (
    input logic custom_srclk,
    input logic reset,
    input logic bus_latch,
    input logic spi_adc_cs,
    input logic spi_dac_cs,
    input logic custom_clksel,
    input logic custom_adc_hwcon
);

    // Property failures so far
    int fail_count = 0;

    // One latch, seven quiet bit times, then the next latch
    latch_period_a : assert property (
        @(posedge custom_srclk) disable iff (reset)
        bus_latch |=> !bus_latch [*7] ##1 bus_latch
    ) else begin
        fail_count++;
        $error("bus_latch spacing is not eight cycles");
    end

    // Outgoing lines stay low while reset is held
    serial_idle_a : assert property (
        @(posedge custom_srclk)
        reset |-> !(spi_adc_cs || spi_dac_cs || custom_clksel || custom_adc_hwcon)
    ) else begin
        fail_count++;
        $error("serial output high during reset");
    end

    // Timer sits at frame start during reset
    latch_in_reset_a : assert property (
        @(posedge custom_srclk) reset |-> bus_latch
    ) else begin
        fail_count++;
        $error("bus_latch low during reset");
    end

endmodule

/* dv/slot_bus_tb.sv */
// Testbench for the slot bus expander with random selects and serial inputs,
// config writes and a mid-run reset; frames are checked against reference functions

`timescale 1ns/1ps

`include "slot_bus_params.svh"

module slot_bus_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int FRAMES_A     = 6;
    localparam int FRAMES_B     = 16;
    localparam int FRAMES_C     = 12;
    localparam int TOTAL_FRAMES = FRAMES_A + FRAMES_B + FRAMES_C;
    // Resets, config writes and the tail on top of the frame time
    localparam int SLACK_CYCLES = 2 * RESET_CYCLES + 80;
    localparam int TIMEOUT_NS   = (TOTAL_FRAMES * `SLOT_FRAME_BITS + SLACK_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        logic                      check_deser;
        slot_bus_pkg::frame_word_t adc;
        slot_bus_pkg::frame_word_t dac;
        slot_bus_pkg::frame_word_t clk;
        slot_bus_pkg::frame_word_t hwcon;
        slot_bus_pkg::frame_word_t ovf;
        slot_bus_pkg::frame_word_t dirchan;
    } frame_entry_t;

    logic                      custom_srclk, reset, cfg_write;
    slot_bus_pkg::cfg_addr_t   cfg_addr;
    slot_bus_pkg::frame_word_t cfg_data;
    slot_bus_pkg::port_mask_t  spi_adc_sel, spi_dac_sel;
    logic                      custom_adc_ovf, custom_dirchan;
    logic                      bus_latch, spi_adc_cs, spi_dac_cs, custom_clksel, custom_adc_hwcon;
    slot_bus_pkg::frame_word_t aovf;
    slot_bus_pkg::port_mask_t  direction, num_channels;

    integer                   seed;
    int                       error_count = 0;
    frame_entry_t             exp_q [$];
    slot_bus_pkg::port_mask_t clksel_model;
    slot_bus_pkg::hwcon_t     hwcon_model [`SLOT_NUM_PORTS];
    int                       frame_count;
    logic [7:0]               ovf_hist, dirchan_hist;

    frame_entry_t cur_exp;
    logic [7:0]   got_adc, got_dac, got_clk, got_hwcon;
    int           bit_num = 0;
    int           frames_checked = 0;
    logic         in_frame = 1'b0;
    logic         start_pending = 1'b0;

    slot_bus_top DUT (.*);

    bind slot_bus_top slot_bus_props u_props (
        .custom_srclk     (custom_srclk),
        .reset            (reset),
        .bus_latch        (bus_latch),
        .spi_adc_cs       (spi_adc_cs),
        .spi_dac_cs       (spi_dac_cs),
        .custom_clksel    (custom_clksel),
        .custom_adc_hwcon (custom_adc_hwcon)
    );

    initial custom_srclk = 1'b0;
    always #(CLK_PERIOD / 2) custom_srclk = ~custom_srclk;

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within the expected number of frames");
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic fail_with_text(input string msg);
        error_count++;
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "Stopping at first error");
    endtask

    // Chip select of port p is low in bit p when selected and the upper nibble is zero
    function automatic slot_bus_pkg::frame_word_t cs_frame_word(
        input slot_bus_pkg::port_mask_t sel);
        slot_bus_pkg::frame_word_t w;
        w = '0;
        for (int p = 0; p < `SLOT_NUM_PORTS; p++) begin
            w[p] = (sel[p] == 1'b1) ? 1'b0 : 1'b1;
        end
        return w;
    endfunction

    function automatic slot_bus_pkg::frame_word_t clksel_frame_word(
        input slot_bus_pkg::port_mask_t mask);
        return {4'b0000, mask};
    endfunction

    function automatic slot_bus_pkg::frame_word_t hwcon_frame_word(input int frame_idx);
        return hwcon_model[frame_idx % `SLOT_NUM_PORTS];
    endfunction

    // History holds the oldest bit at index 0, which becomes the word MSB
    function automatic slot_bus_pkg::frame_word_t deser_word(input logic [7:0] hist);
        slot_bus_pkg::frame_word_t w;
        for (int i = 0; i < `SLOT_FRAME_BITS; i++) begin
            w[`SLOT_FRAME_BITS - 1 - i] = hist[i];
        end
        return w;
    endfunction

    task automatic clear_models;
        clksel_model = '0;
        for (int p = 0; p < `SLOT_NUM_PORTS; p++) begin
            hwcon_model[p] = '0;
        end
        frame_count  = 0;
        ovf_hist     = '0;
        dirchan_hist = '0;
    endtask

    // One bit time; expected words are queued when the coming edge loads a frame
    task automatic run_cycle(input logic wr, input slot_bus_pkg::cfg_addr_t addr,
                             input slot_bus_pkg::frame_word_t data);
        logic [31:0]  r;
        logic         latch_now;
        frame_entry_t e;
        @(negedge custom_srclk);
        latch_now = bus_latch;
        r = $random(seed);
        reset          <= 1'b0;
        spi_adc_sel    <= r[3:0];
        spi_dac_sel    <= r[7:4];
        custom_adc_ovf <= r[8];
        custom_dirchan <= r[9];
        cfg_write      <= wr;
        cfg_addr       <= addr;
        cfg_data       <= data;
        ovf_hist     = {r[8], ovf_hist[7:1]};
        dirchan_hist = {r[9], dirchan_hist[7:1]};
        if (latch_now) begin
            e.check_deser = (frame_count != 0);
            e.adc     = cs_frame_word(r[3:0]);
            e.dac     = cs_frame_word(r[7:4]);
            e.clk     = clksel_frame_word(clksel_model);
            e.hwcon   = hwcon_frame_word(frame_count);
            e.ovf     = deser_word(ovf_hist);
            e.dirchan = deser_word(dirchan_hist);
            exp_q.push_back(e);
            frame_count++;
        end
        // A write on the load edge only reaches the following frame
        if (wr && addr < `SLOT_NUM_PORTS) begin
            hwcon_model[addr[1:0]] = data;
        end else if (wr && addr == `SLOT_CFG_CLKSEL_ADDR) begin
            clksel_model = data[3:0];
        end
    endtask

    task automatic run_frames(input int n);
        repeat (n * `SLOT_FRAME_BITS) run_cycle(1'b0, '0, '0);
    endtask

    task automatic hold_reset;
        @(negedge custom_srclk);
        reset     <= 1'b1;
        cfg_write <= 1'b0;
        clear_models();
        @(negedge custom_srclk);
        exp_q.delete();
        repeat (RESET_CYCLES - 2) @(negedge custom_srclk);
    endtask

    // Bound property failures end the run like any other check
    always @(DUT.u_props.fail_count) begin
        assert (DUT.u_props.fail_count == 0)
            else fail_with_text("a bound property assertion failed");
    end

    // Comparing process collects the eight serial bits that follow each latch
    always @(negedge custom_srclk) begin
        if (reset) begin
            in_frame = 1'b0;
            check_value("bus_latch", {7'b0, bus_latch}, 8'h01);
            check_value("aovf", aovf, 8'h00);
            check_value("{num_channels, direction}", {num_channels, direction}, 8'h00);
            check_value("serial outputs", {4'b0, spi_adc_cs, spi_dac_cs, custom_clksel,
                        custom_adc_hwcon}, 8'h00);
        end else begin
            if (start_pending) begin
                assert (exp_q.size() > 0) else fail_with_text("latch seen with no frame expected");
                cur_exp  = exp_q.pop_front();
                in_frame = 1'b1;
                bit_num  = 0;
            end
            if (in_frame) begin
                got_adc[7 - bit_num]   = spi_adc_cs;
                got_dac[7 - bit_num]   = spi_dac_cs;
                got_clk[7 - bit_num]   = custom_clksel;
                got_hwcon[7 - bit_num] = custom_adc_hwcon;
                check_value("bus_latch", {7'b0, bus_latch}, (bit_num == 7) ? 8'h01 : 8'h00);
                if (cur_exp.check_deser) begin
                    check_value("aovf", aovf, cur_exp.ovf);
                    check_value("{num_channels, direction}", {num_channels, direction},
                                cur_exp.dirchan);
                end
                bit_num++;
                if (bit_num == `SLOT_FRAME_BITS) begin
                    check_value("spi_adc_cs", got_adc, cur_exp.adc);
                    check_value("spi_dac_cs", got_dac, cur_exp.dac);
                    check_value("custom_clksel", got_clk, cur_exp.clk);
                    check_value("custom_adc_hwcon", got_hwcon, cur_exp.hwcon);
                    frames_checked++;
                    in_frame = 1'b0;
                end
            end
        end
        start_pending = bus_latch;
    end

    initial begin
        seed           = 32'hed590a9a;
        reset          = 1'b1;
        cfg_write      = 1'b0;
        cfg_addr       = '0;
        cfg_data       = '0;
        spi_adc_sel    = '0;
        spi_dac_sel    = '0;
        custom_adc_ovf = 1'b0;
        custom_dirchan = 1'b0;
        clear_models();
        repeat (RESET_CYCLES - 1) @(negedge custom_srclk);
        run_frames(FRAMES_A);
        for (int p = 0; p < `SLOT_NUM_PORTS; p++) begin
            run_cycle(1'b1, slot_bus_pkg::cfg_addr_t'(p), slot_bus_pkg::frame_word_t'($random(seed)));
        end
        run_cycle(1'b1, 3'd5, 8'hff);
        run_cycle(1'b1, slot_bus_pkg::cfg_addr_t'(`SLOT_CFG_CLKSEL_ADDR),
                  slot_bus_pkg::frame_word_t'($random(seed)));
        run_frames(FRAMES_B);
        // Reset lands in the middle of a frame
        repeat (3) run_cycle(1'b0, '0, '0);
        hold_reset();
        run_cycle(1'b1, slot_bus_pkg::cfg_addr_t'(`SLOT_CFG_CLKSEL_ADDR),
                  slot_bus_pkg::frame_word_t'($random(seed)));
        run_cycle(1'b1, 3'd1, slot_bus_pkg::frame_word_t'($random(seed)));
        run_cycle(1'b1, 3'd2, slot_bus_pkg::frame_word_t'($random(seed)));
        run_frames(FRAMES_C);
        repeat (`SLOT_FRAME_BITS + 1) run_cycle(1'b0, '0, '0);
        @(posedge custom_srclk);
        assert (frames_checked >= TOTAL_FRAMES) else fail_with_text("too few frames were checked");
        if (error_count == 0 && DUT.u_props.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
source/slot_bus_pkg.sv
source/frame_timer.sv
source/slot_config_regs.sv
source/frame_serializer.sv
source/frame_deserializer.sv
source/slot_bus_top.sv
dv/slot_bus_props.sv
dv/slot_bus_tb.sv

/* Bender.yml */
package:
  name: slot_bus

export_include_dirs:
  - include

sources:
  - source/slot_bus_pkg.sv
  - source/frame_timer.sv
  - source/slot_config_regs.sv
  - source/frame_serializer.sv
  - source/frame_deserializer.sv
  - source/slot_bus_top.sv
  - target: test
    files:
      - dv/slot_bus_props.sv
      - dv/slot_bus_tb.sv
